// ==== Bender.yml ====
package:
  name: eth_tx_mux

sources:
  # Design, in compile order
  - rtl/eth_tx_pkg.sv
  - rtl/eth_packet_fifo.sv
  - rtl/eth_frame_queue.sv
  - rtl/eth_tx_arbiter.sv
  - rtl/eth_tx_mux_top.sv

  # Testbench, top module eth_tx_mux_tb
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/eth_tx_mux_tb.sv

// ==== eth_tx_mux.f ====
+incdir+verif
rtl/eth_tx_pkg.sv
rtl/eth_packet_fifo.sv
rtl/eth_frame_queue.sv
rtl/eth_tx_arbiter.sv
rtl/eth_tx_mux_top.sv
verif/eth_tx_mux_tb.sv

// ==== rtl/eth_frame_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module eth_frame_queue (
	input wire clk,
	input wire reset,

	// Layer-3 source
	input wire start,
	input wire data_valid,
	input wire eth_tx_pkg::word_bytes_t bytes_valid,
	input wire eth_tx_pkg::tx_word_t data,
	input wire commit,
	input wire drop,
	input wire eth_tx_pkg::mac_addr_t dst_mac,

	// Arbiter side
	input wire rd_next,
	input wire rd_release,
	output logic hdr_valid,
	output eth_tx_pkg::byte_count_t hdr_len,
	output eth_tx_pkg::mac_addr_t hdr_mac,
	output eth_tx_pkg::tx_word_t rd_data,

	output eth_tx_pkg::perf_count_t perf_sent,
	output eth_tx_pkg::perf_count_t perf_dropped
);

	//////////////////////////////
	// Frame intake

	logic frame_active;
	logic space_ok;
	logic accept;
	logic refuse;
	logic frame_commit;
	logic frame_drop;
	logic word_wr;
	eth_tx_pkg::byte_count_t frame_len;
	eth_tx_pkg::word_ptr_t free_words;

	// Header ring, one entry per committed frame
	eth_tx_pkg::byte_count_t len_mem [eth_tx_pkg::HEADER_DEPTH];
	eth_tx_pkg::mac_addr_t mac_mem [eth_tx_pkg::HEADER_DEPTH];
	logic [eth_tx_pkg::HEADER_ADDR_BITS:0] hdr_wr_ptr;
	logic [eth_tx_pkg::HEADER_ADDR_BITS:0] hdr_rd_ptr;
	logic [eth_tx_pkg::HEADER_ADDR_BITS:0] hdr_count;

	assign hdr_count = hdr_wr_ptr - hdr_rd_ptr;

	// Room for a full-size frame and a free header slot
	assign space_ok = (free_words > eth_tx_pkg::MAX_FRAME_WORDS) &&
		(hdr_count < eth_tx_pkg::HEADER_DEPTH);
	assign accept = start && space_ok;
	assign refuse = start && !space_ok;

	// End strobes only matter for an accepted frame
	assign frame_commit = commit && frame_active;
	assign frame_drop = drop && frame_active;

	// A word may ride along with start
	assign word_wr = data_valid && (frame_active || accept);

	always_ff @(posedge clk) begin
		if (reset) begin
			frame_active <= 1'b0;
			frame_len <= '0;
		end else begin
			if (accept) begin
				frame_active <= 1'b1;
				frame_len <= data_valid ? eth_tx_pkg::byte_count_t'(bytes_valid) : '0;
			end else if (frame_active && data_valid) begin
				frame_len <= frame_len + bytes_valid;
			end

			if (frame_commit || frame_drop) begin
				frame_active <= 1'b0;
			end
		end
	end

	eth_packet_fifo payload_fifo (
		.clk(clk),
		.reset(reset),
		.wr_en(word_wr),
		.wr_data(data),
		.wr_commit(frame_commit),
		.wr_rollback(frame_drop),
		.rd_next(rd_next),
		.rd_release(rd_release),
		.rd_data(rd_data),
		.free_words(free_words)
	);

	//////////////////////////////
	// Header ring

	// Length is complete at commit, MAC sampled there too
	always_ff @(posedge clk) begin
		if (frame_commit) begin
			len_mem[hdr_wr_ptr[eth_tx_pkg::HEADER_ADDR_BITS-1:0]] <= frame_len;
			mac_mem[hdr_wr_ptr[eth_tx_pkg::HEADER_ADDR_BITS-1:0]] <= dst_mac;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			hdr_wr_ptr <= '0;
			hdr_rd_ptr <= '0;
		end else begin
			if (frame_commit) begin
				hdr_wr_ptr <= hdr_wr_ptr + 1'b1;
			end
			// Popped as the frame's last word goes out
			if (rd_release) begin
				hdr_rd_ptr <= hdr_rd_ptr + 1'b1;
			end
		end
	end

	assign hdr_valid = (hdr_wr_ptr != hdr_rd_ptr);
	assign hdr_len = len_mem[hdr_rd_ptr[eth_tx_pkg::HEADER_ADDR_BITS-1:0]];
	assign hdr_mac = mac_mem[hdr_rd_ptr[eth_tx_pkg::HEADER_ADDR_BITS-1:0]];

	//////////////////////////////
	// Perf counters

	always_ff @(posedge clk) begin
		if (reset) begin
			perf_sent <= '0;
			perf_dropped <= '0;
		end else begin
			if (frame_commit) begin
				perf_sent <= perf_sent + 64'd1;
			end
			// Refused at start, or abandoned by the source
			if (refuse || frame_drop) begin
				perf_dropped <= perf_dropped + 64'd1;
			end
		end
	end

	// Source must mark at least one byte per word
	a_bytes_valid_range: assert property (@(posedge clk) disable iff (reset)
		(data_valid && (frame_active || accept)) |->
			(bytes_valid >= 3'd1 && bytes_valid <= 3'd4))
		else $error("bytes_valid out of range");

endmodule

`default_nettype wire

// ==== rtl/eth_packet_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module eth_packet_fifo (
	input wire clk,
	input wire reset,

	// Write side, from the frame intake
	input wire wr_en,
	input wire eth_tx_pkg::tx_word_t wr_data,
	input wire wr_commit,
	input wire wr_rollback,

	// Read side, from the arbiter
	input wire rd_next,
	input wire rd_release,
	output eth_tx_pkg::tx_word_t rd_data,

	output eth_tx_pkg::word_ptr_t free_words
);

	//////////////////////////////
	// Storage and pointers

	eth_tx_pkg::tx_word_t mem [eth_tx_pkg::PAYLOAD_DEPTH];

	// Working pointer moves with every accepted word
	eth_tx_pkg::word_ptr_t wr_ptr;
	// Committed pointer marks the end of the last whole frame
	eth_tx_pkg::word_ptr_t commit_ptr;
	// Read pointer walks the frame being sent
	eth_tx_pkg::word_ptr_t rd_ptr;
	// Release pointer frees space up to the last sent frame
	eth_tx_pkg::word_ptr_t rel_ptr;

	eth_tx_pkg::word_ptr_t rd_ptr_next;

	assign rd_ptr_next = rd_next ? rd_ptr + 1'b1 : rd_ptr;

	// Space held by the frame in progress counts as used
	assign free_words = eth_tx_pkg::word_ptr_t'(eth_tx_pkg::PAYLOAD_DEPTH) - (wr_ptr - rel_ptr);

	// Word at the read pointer, no strobe needed
	assign rd_data = mem[rd_ptr[eth_tx_pkg::PAYLOAD_ADDR_BITS-1:0]];

	always_ff @(posedge clk) begin
		if (wr_en && !wr_rollback) begin
			mem[wr_ptr[eth_tx_pkg::PAYLOAD_ADDR_BITS-1:0]] <= wr_data;
		end
	end

	//////////////////////////////
	// Pointer updates

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			commit_ptr <= '0;
			rd_ptr <= '0;
			rel_ptr <= '0;
		end else begin
			// Dropped frame gives its words back
			if (wr_rollback) begin
				wr_ptr <= commit_ptr;
			end else if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end

			// Frame becomes readable
			if (wr_commit) begin
				commit_ptr <= wr_ptr;
			end

			rd_ptr <= rd_ptr_next;

			// Includes the word read in the same cycle
			if (rd_release) begin
				rel_ptr <= rd_ptr_next;
			end
		end
	end

	// Intake admission must keep the store from overflowing
	a_no_write_when_full: assert property (@(posedge clk) disable iff (reset)
		wr_en |-> free_words != '0)
		else $error("payload write with no free words");

	// Arbiter reads only committed words
	a_read_in_committed: assert property (@(posedge clk) disable iff (reset)
		rd_next |-> rd_ptr != commit_ptr)
		else $error("read pointer passed committed pointer");

endmodule

`default_nettype wire

// ==== rtl/eth_tx_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module eth_tx_arbiter (
	input wire clk,
	input wire reset,

	// ARP queue
	input wire arp_hdr_valid,
	input wire eth_tx_pkg::byte_count_t arp_hdr_len,
	input wire eth_tx_pkg::mac_addr_t arp_hdr_mac,
	input wire eth_tx_pkg::tx_word_t arp_rd_data,
	output logic arp_rd_next,
	output logic arp_release,

	// IPv4 queue
	input wire ipv4_hdr_valid,
	input wire eth_tx_pkg::byte_count_t ipv4_hdr_len,
	input wire eth_tx_pkg::mac_addr_t ipv4_hdr_mac,
	input wire eth_tx_pkg::tx_word_t ipv4_rd_data,
	output logic ipv4_rd_next,
	output logic ipv4_release,

	// Layer-2 output to the MAC
	output logic tx_start,
	output logic tx_data_valid,
	output eth_tx_pkg::word_bytes_t tx_bytes_valid,
	output eth_tx_pkg::tx_word_t tx_data,
	output logic tx_commit,
	output eth_tx_pkg::mac_addr_t tx_dst_mac,
	output eth_tx_pkg::ethertype_t tx_ethertype
);

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_HEADER,
		ARB_BODY,
		ARB_COMMIT
	} arb_state_t;

	arb_state_t state;

	// Set while the IPv4 queue is being served
	logic serve_ipv4;

	// Bytes still to send, including the current word
	eth_tx_pkg::byte_count_t bytes_left;
	logic last_word;

	assign last_word = (bytes_left <= 16'd4);

	//////////////////////////////
	// Priority FSM

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ARB_IDLE;
			serve_ipv4 <= 1'b0;
			bytes_left <= '0;
			tx_dst_mac <= '0;
			tx_ethertype <= '0;
		end else begin
			case (state)
				ARB_IDLE: begin
					// ARP always goes first
					if (arp_hdr_valid) begin
						serve_ipv4 <= 1'b0;
						bytes_left <= arp_hdr_len;
						tx_dst_mac <= arp_hdr_mac;
						tx_ethertype <= eth_tx_pkg::ETHERTYPE_ARP;
						state <= ARB_HEADER;
					end else if (ipv4_hdr_valid) begin
						serve_ipv4 <= 1'b1;
						bytes_left <= ipv4_hdr_len;
						tx_dst_mac <= ipv4_hdr_mac;
						tx_ethertype <= eth_tx_pkg::ETHERTYPE_IPV4;
						state <= ARB_HEADER;
					end
				end

				// Start strobe goes out here, MAC and ethertype already held
				ARB_HEADER: begin
					state <= ARB_BODY;
				end

				// One word per cycle, no back-pressure
				ARB_BODY: begin
					if (last_word) begin
						bytes_left <= '0;
						state <= ARB_COMMIT;
					end else begin
						bytes_left <= bytes_left - 16'd4;
					end
				end

				ARB_COMMIT: begin
					state <= ARB_IDLE;
				end

				default: begin
					state <= ARB_IDLE;
				end
			endcase
		end
	end

	//////////////////////////////
	// Output decode

	assign tx_start = (state == ARB_HEADER);
	assign tx_data_valid = (state == ARB_BODY);
	assign tx_commit = (state == ARB_COMMIT);

	// Short last word carries the remainder
	assign tx_bytes_valid = !tx_data_valid ? 3'd0 : (last_word ? bytes_left[2:0] : 3'd4);

	assign tx_data = !tx_data_valid ? '0 : (serve_ipv4 ? ipv4_rd_data : arp_rd_data);

	// Advance the served queue on every word
	assign arp_rd_next = tx_data_valid && !serve_ipv4;
	assign ipv4_rd_next = tx_data_valid && serve_ipv4;

	// Free the frame on its last word so the next header is ready by idle
	assign arp_release = arp_rd_next && last_word;
	assign ipv4_release = ipv4_rd_next && last_word;

	// A zero-length header would put an empty word on the bus
	a_word_has_bytes: assert property (@(posedge clk) disable iff (reset)
		tx_data_valid |-> bytes_left != '0)
		else $error("data word with no bytes left in the frame");

endmodule

`default_nettype wire

// ==== rtl/eth_tx_mux_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module eth_tx_mux_top (
	input wire clk,
	input wire reset,

	// ARP source
	input wire arp_start,
	input wire arp_data_valid,
	input wire eth_tx_pkg::word_bytes_t arp_bytes_valid,
	input wire eth_tx_pkg::tx_word_t arp_data,
	input wire arp_commit,
	input wire arp_drop,
	input wire eth_tx_pkg::mac_addr_t arp_dst_mac,

	// IPv4 source
	input wire ipv4_start,
	input wire ipv4_data_valid,
	input wire eth_tx_pkg::word_bytes_t ipv4_bytes_valid,
	input wire eth_tx_pkg::tx_word_t ipv4_data,
	input wire ipv4_commit,
	input wire ipv4_drop,
	input wire eth_tx_pkg::mac_addr_t ipv4_dst_mac,

	// To the MAC
	output logic tx_start,
	output logic tx_data_valid,
	output eth_tx_pkg::word_bytes_t tx_bytes_valid,
	output eth_tx_pkg::tx_word_t tx_data,
	output logic tx_commit,
	output eth_tx_pkg::mac_addr_t tx_dst_mac,
	output eth_tx_pkg::ethertype_t tx_ethertype,

	output eth_tx_pkg::perf_count_t perf_arp_sent,
	output eth_tx_pkg::perf_count_t perf_arp_dropped,
	output eth_tx_pkg::perf_count_t perf_ipv4_sent,
	output eth_tx_pkg::perf_count_t perf_ipv4_dropped
);

	//////////////////////////////
	// Queue to arbiter wiring

	logic arp_hdr_valid;
	eth_tx_pkg::byte_count_t arp_hdr_len;
	eth_tx_pkg::mac_addr_t arp_hdr_mac;
	eth_tx_pkg::tx_word_t arp_rd_data;
	logic arp_rd_next;
	logic arp_release;

	logic ipv4_hdr_valid;
	eth_tx_pkg::byte_count_t ipv4_hdr_len;
	eth_tx_pkg::mac_addr_t ipv4_hdr_mac;
	eth_tx_pkg::tx_word_t ipv4_rd_data;
	logic ipv4_rd_next;
	logic ipv4_release;

	eth_frame_queue arp_queue (
		.clk(clk),
		.reset(reset),
		.start(arp_start),
		.data_valid(arp_data_valid),
		.bytes_valid(arp_bytes_valid),
		.data(arp_data),
		.commit(arp_commit),
		.drop(arp_drop),
		.dst_mac(arp_dst_mac),
		.rd_next(arp_rd_next),
		.rd_release(arp_release),
		.hdr_valid(arp_hdr_valid),
		.hdr_len(arp_hdr_len),
		.hdr_mac(arp_hdr_mac),
		.rd_data(arp_rd_data),
		.perf_sent(perf_arp_sent),
		.perf_dropped(perf_arp_dropped)
	);

	eth_frame_queue ipv4_queue (
		.clk(clk),
		.reset(reset),
		.start(ipv4_start),
		.data_valid(ipv4_data_valid),
		.bytes_valid(ipv4_bytes_valid),
		.data(ipv4_data),
		.commit(ipv4_commit),
		.drop(ipv4_drop),
		.dst_mac(ipv4_dst_mac),
		.rd_next(ipv4_rd_next),
		.rd_release(ipv4_release),
		.hdr_valid(ipv4_hdr_valid),
		.hdr_len(ipv4_hdr_len),
		.hdr_mac(ipv4_hdr_mac),
		.rd_data(ipv4_rd_data),
		.perf_sent(perf_ipv4_sent),
		.perf_dropped(perf_ipv4_dropped)
	);

	//////////////////////////////
	// Output arbitration

	eth_tx_arbiter arbiter (
		.clk(clk),
		.reset(reset),
		.arp_hdr_valid(arp_hdr_valid),
		.arp_hdr_len(arp_hdr_len),
		.arp_hdr_mac(arp_hdr_mac),
		.arp_rd_data(arp_rd_data),
		.arp_rd_next(arp_rd_next),
		.arp_release(arp_release),
		.ipv4_hdr_valid(ipv4_hdr_valid),
		.ipv4_hdr_len(ipv4_hdr_len),
		.ipv4_hdr_mac(ipv4_hdr_mac),
		.ipv4_rd_data(ipv4_rd_data),
		.ipv4_rd_next(ipv4_rd_next),
		.ipv4_release(ipv4_release),
		.tx_start(tx_start),
		.tx_data_valid(tx_data_valid),
		.tx_bytes_valid(tx_bytes_valid),
		.tx_data(tx_data),
		.tx_commit(tx_commit),
		.tx_dst_mac(tx_dst_mac),
		.tx_ethertype(tx_ethertype)
	);

endmodule

`default_nettype wire

// ==== rtl/eth_tx_pkg.sv ====
`default_nettype none

package eth_tx_pkg;

	//////////////////////////////
	// Sizes

	// Payload words per queue
	localparam int PAYLOAD_DEPTH = 1024;
	localparam int PAYLOAD_ADDR_BITS = $clog2(PAYLOAD_DEPTH);

	// Committed frames one header ring can hold
	localparam int HEADER_DEPTH = 16;
	localparam int HEADER_ADDR_BITS = $clog2(HEADER_DEPTH);

	// Free words a new frame needs, 1500 bytes worth
	localparam int MAX_FRAME_WORDS = 375;

	//////////////////////////////
	// Types

	// One payload word on any of the buses
	typedef logic [31:0] tx_word_t;

	// Valid bytes in a word, 1 to 4
	typedef logic [2:0] word_bytes_t;

	// Frame length in bytes
	typedef logic [15:0] byte_count_t;

	typedef logic [47:0] mac_addr_t;
	typedef logic [15:0] ethertype_t;

	// Sent and dropped frame counters
	typedef logic [63:0] perf_count_t;

	// Payload address plus wrap bit
	typedef logic [PAYLOAD_ADDR_BITS:0] word_ptr_t;

	// Layer-3 protocol tags
	localparam ethertype_t ETHERTYPE_ARP = 16'h0806;
	localparam ethertype_t ETHERTYPE_IPV4 = 16'h0800;

endpackage

`default_nettype wire

// ==== verif/eth_tx_mux_tasks.svh ====
`ifndef ETH_TX_MUX_TASKS_SVH
`define ETH_TX_MUX_TASKS_SVH

//////////////////////////////
// Expected-frame model

// Frames that should reach the MAC, bytes kept flat per protocol
eth_tx_pkg::mac_addr_t arp_mac_q[$];
int arp_len_q[$];
int arp_cyc_q[$];
logic [7:0] arp_byte_q[$];
eth_tx_pkg::mac_addr_t ipv4_mac_q[$];
int ipv4_len_q[$];
int ipv4_cyc_q[$];
logic [7:0] ipv4_byte_q[$];

task automatic report_mismatch(input string what, input logic [63:0] exp_val,
	input logic [63:0] act_val);
	$display("MISMATCH test %s %s expected %0h actual %0h", cur_test, what, exp_val, act_val);
	mismatch_count++;
endtask

task automatic report_error(input string what);
	$display("ERROR in test %s at cycle %0d: %s", cur_test, cycle_count, what);
	error_count++;
endtask

function automatic eth_tx_pkg::mac_addr_t random_mac();
	logic [63:0] r;
	r = {$urandom, $urandom};
	return r[47:0];
endfunction

function automatic logic [7:0] random_byte();
	logic [31:0] r;
	r = $urandom;
	return r[7:0];
endfunction

function automatic logic [7:0] pop_expected_byte(input logic is_arp);
	if (is_arp) begin
		return arp_byte_q.pop_front();
	end
	return ipv4_byte_q.pop_front();
endfunction

// Oldest frame of one protocol becomes the frame the monitor follows
task automatic take_expected(input logic is_arp);
	mon_is_arp = is_arp;
	if (is_arp) begin
		mon_type = ARP_TYPE;
		mon_exp_mac = arp_mac_q.pop_front();
		mon_bytes_left = arp_len_q.pop_front();
		arp_cyc_q.delete(0);
	end else begin
		mon_type = IPV4_TYPE;
		mon_exp_mac = ipv4_mac_q.pop_front();
		mon_bytes_left = ipv4_len_q.pop_front();
		ipv4_cyc_q.delete(0);
	end
	mon_words_left = (mon_bytes_left + 3) / 4;
	mon_in_frame = 1'b1;
endtask

// Keeps the byte stream aligned after a broken frame
task automatic discard_expected_bytes();
	while (mon_bytes_left > 0) begin
		mon_exp_byte = pop_expected_byte(mon_is_arp);
		mon_bytes_left--;
	end
	mon_in_frame = 1'b0;
endtask

//////////////////////////////
// Source drivers

task automatic drive_source(input logic is_arp, input logic st, input logic dv,
	input eth_tx_pkg::word_bytes_t bv, input eth_tx_pkg::tx_word_t d, input logic cm,
	input logic dr, input eth_tx_pkg::mac_addr_t mac);
	if (is_arp) begin
		arp_start = st;
		arp_data_valid = dv;
		arp_bytes_valid = bv;
		arp_data = d;
		arp_commit = cm;
		arp_drop = dr;
		arp_dst_mac = mac;
	end else begin
		ipv4_start = st;
		ipv4_data_valid = dv;
		ipv4_bytes_valid = bv;
		ipv4_data = d;
		ipv4_commit = cm;
		ipv4_drop = dr;
		ipv4_dst_mac = mac;
	end
endtask

// Start, one word per cycle, commit or drop, then one quiet cycle
task automatic send_frame(input logic is_arp, input int nbytes, input logic do_drop,
	input logic expect_out, output int commit_cyc);
	logic [7:0] bytes[$];
	eth_tx_pkg::mac_addr_t mac;
	eth_tx_pkg::tx_word_t word;
	int nwords;
	int lanes;
	int i;
	int w;
	int b;
	mac = random_mac();
	nwords = (nbytes + 3) / 4;
	for (i = 0; i < nbytes; i++) begin
		bytes.push_back(random_byte());
	end
	@(negedge clk);
	drive_source(is_arp, 1'b1, 1'b0, 3'd0, '0, 1'b0, 1'b0, '0);
	for (w = 0; w < nwords; w++) begin
		lanes = (nbytes - 4 * w > 4) ? 4 : nbytes - 4 * w;
		// First byte in the low lane, unused lanes zero
		word = '0;
		for (b = 0; b < lanes; b++) begin
			word[8*b +: 8] = bytes[4*w + b];
		end
		@(negedge clk);
		drive_source(is_arp, 1'b0, 1'b1, 3'(lanes), word, 1'b0, 1'b0, '0);
	end
	@(negedge clk);
	drive_source(is_arp, 1'b0, 1'b0, 3'd0, '0, !do_drop, do_drop, mac);
	commit_cyc = cycle_count;
	if (expect_out && !do_drop) begin
		for (i = 0; i < nbytes; i++) begin
			if (is_arp) begin
				arp_byte_q.push_back(bytes[i]);
			end else begin
				ipv4_byte_q.push_back(bytes[i]);
			end
		end
		if (is_arp) begin
			arp_mac_q.push_back(mac);
			arp_len_q.push_back(nbytes);
			arp_cyc_q.push_back(commit_cyc);
		end else begin
			ipv4_mac_q.push_back(mac);
			ipv4_len_q.push_back(nbytes);
			ipv4_cyc_q.push_back(commit_cyc);
		end
	end
	@(negedge clk);
	drive_source(is_arp, 1'b0, 1'b0, 3'd0, '0, 1'b0, 1'b0, '0);
endtask

// Every expected frame out and the last one closed
task automatic wait_tx_idle();
	while (arp_len_q.size() != 0 || ipv4_len_q.size() != 0 || mon_in_frame) begin
		@(negedge clk);
	end
	@(negedge clk);
endtask

task automatic check_order(input int count, input logic [15:0] first_type,
	input int first_run);
	int i;
	if (seen_types.size() != count) begin
		report_mismatch("frame count", 64'(count), 64'(seen_types.size()));
	end else begin
		// first_run frames of first_type, then the other protocol
		for (i = 0; i < count; i++) begin
			if (i < first_run && seen_types[i] != first_type) begin
				report_mismatch("ethertype order", 64'(first_type), 64'(seen_types[i]));
			end
			if (i >= first_run && seen_types[i] == first_type) begin
				report_mismatch("ethertype order", 64'(first_type ^ 16'h0006),
					64'(seen_types[i]));
			end
		end
	end
endtask

//////////////////////////////
// Tests

task automatic check_reset_state();
	cur_test = "reset";
	if (tx_start || tx_data_valid || tx_commit) begin
		report_error("output strobe high right after reset");
	end
	if (tx_dst_mac != '0) begin
		report_mismatch("dst_mac", 64'd0, 64'(tx_dst_mac));
	end
	if (tx_ethertype != '0) begin
		report_mismatch("ethertype", 64'd0, 64'(tx_ethertype));
	end
	if ((perf_arp_sent | perf_arp_dropped | perf_ipv4_sent | perf_ipv4_dropped) != '0) begin
		report_error("perf counters not zero after reset");
	end
endtask

task automatic test_ipv4_single();
	eth_tx_pkg::perf_count_t sent_before;
	int nbytes;
	int cc;
	cur_test = "ipv4_single";
	seen_types.delete();
	sent_before = perf_ipv4_sent;
	nbytes = $urandom_range(64, 1);
	send_frame(1'b0, nbytes, 1'b0, 1'b1, cc);
	wait_tx_idle();
	// Idle arbiter: start two cycles after commit, commit right after the words
	if (last_start_cyc != cc + 2) begin
		report_mismatch("start cycle", 64'(cc + 2), 64'(last_start_cyc));
	end
	if (last_commit_cyc != cc + 3 + (nbytes + 3) / 4) begin
		report_mismatch("commit cycle", 64'(cc + 3 + (nbytes + 3) / 4), 64'(last_commit_cyc));
	end
	if (perf_ipv4_sent != sent_before + 64'd1) begin
		report_mismatch("perf_ipv4_sent", sent_before + 64'd1, perf_ipv4_sent);
	end
	check_order(1, IPV4_TYPE, 1);
endtask

task automatic test_drop_then_send();
	eth_tx_pkg::perf_count_t sent_before;
	eth_tx_pkg::perf_count_t dropped_before;
	int cc;
	cur_test = "drop_then_send";
	seen_types.delete();
	sent_before = perf_arp_sent;
	dropped_before = perf_arp_dropped;
	send_frame(1'b1, $urandom_range(64, 1), 1'b1, 1'b0, cc);
	send_frame(1'b1, $urandom_range(64, 1), 1'b0, 1'b1, cc);
	wait_tx_idle();
	if (perf_arp_sent != sent_before + 64'd1) begin
		report_mismatch("perf_arp_sent", sent_before + 64'd1, perf_arp_sent);
	end
	if (perf_arp_dropped != dropped_before + 64'd1) begin
		report_mismatch("perf_arp_dropped", dropped_before + 64'd1, perf_arp_dropped);
	end
	check_order(1, ARP_TYPE, 1);
endtask

task automatic test_arp_priority();
	int cc;
	cur_test = "arp_priority";
	seen_types.delete();
	// 200 words keep the arbiter busy while the short frames commit
	send_frame(1'b0, 800, 1'b0, 1'b1, cc);
	send_frame(1'b0, $urandom_range(32, 1), 1'b0, 1'b1, cc);
	send_frame(1'b1, $urandom_range(32, 1), 1'b0, 1'b1, cc);
	wait_tx_idle();
	if (seen_types.size() != 3) begin
		report_mismatch("frame count", 64'd3, 64'(seen_types.size()));
	end else begin
		// Long IPv4 frame, then ARP ahead of the short IPv4 frame
		if (seen_types[0] != IPV4_TYPE) begin
			report_mismatch("first frame ethertype", 64'(IPV4_TYPE), 64'(seen_types[0]));
		end
		if (seen_types[1] != ARP_TYPE) begin
			report_mismatch("second frame ethertype", 64'(ARP_TYPE), 64'(seen_types[1]));
		end
		if (seen_types[2] != IPV4_TYPE) begin
			report_mismatch("third frame ethertype", 64'(IPV4_TYPE), 64'(seen_types[2]));
		end
	end
endtask

task automatic test_header_full();
	eth_tx_pkg::perf_count_t sent_before;
	eth_tx_pkg::perf_count_t dropped_before;
	int cc;
	int i;
	cur_test = "header_full";
	seen_types.delete();
	sent_before = perf_ipv4_sent;
	dropped_before = perf_ipv4_dropped;
	send_frame(1'b1, 1500, 1'b0, 1'b1, cc);
	// Seventeenth frame finds all 16 header slots taken
	for (i = 0; i < 17; i++) begin
		send_frame(1'b0, $urandom_range(4, 1), 1'b0, i < 16, cc);
	end
	wait_tx_idle();
	if (perf_ipv4_sent != sent_before + 64'd16) begin
		report_mismatch("perf_ipv4_sent", sent_before + 64'd16, perf_ipv4_sent);
	end
	if (perf_ipv4_dropped != dropped_before + 64'd1) begin
		report_mismatch("perf_ipv4_dropped", dropped_before + 64'd1, perf_ipv4_dropped);
	end
	check_order(17, ARP_TYPE, 1);
endtask

task automatic test_payload_full();
	eth_tx_pkg::perf_count_t arp_before;
	eth_tx_pkg::perf_count_t sent_before;
	eth_tx_pkg::perf_count_t dropped_before;
	int cc;
	int cc_ipv4;
	cur_test = "payload_full";
	seen_types.delete();
	arp_before = perf_arp_sent;
	sent_before = perf_ipv4_sent;
	dropped_before = perf_ipv4_dropped;
	send_frame(1'b1, 1500, 1'b0, 1'b1, cc);
	fork
		send_frame(1'b1, 1500, 1'b0, 1'b1, cc);
		begin
			// Third frame sees 1024 - 660 = 364 free words
			send_frame(1'b0, 1320, 1'b0, 1'b1, cc_ipv4);
			send_frame(1'b0, 1320, 1'b0, 1'b1, cc_ipv4);
			send_frame(1'b0, 1320, 1'b0, 1'b0, cc_ipv4);
		end
	join
	wait_tx_idle();
	if (perf_arp_sent != arp_before + 64'd2) begin
		report_mismatch("perf_arp_sent", arp_before + 64'd2, perf_arp_sent);
	end
	if (perf_ipv4_sent != sent_before + 64'd2) begin
		report_mismatch("perf_ipv4_sent", sent_before + 64'd2, perf_ipv4_sent);
	end
	if (perf_ipv4_dropped != dropped_before + 64'd1) begin
		report_mismatch("perf_ipv4_dropped", dropped_before + 64'd1, perf_ipv4_dropped);
	end
	check_order(4, ARP_TYPE, 2);
endtask

`endif

// ==== verif/eth_tx_mux_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module eth_tx_mux_tb;

	// Roughly twice the cycles the five tests need
	localparam int CYCLE_LIMIT = 6000;

	// Ethertypes as the MAC should see them
	localparam logic [15:0] ARP_TYPE = 16'h0806;
	localparam logic [15:0] IPV4_TYPE = 16'h0800;

	logic clk;
	logic reset;

	// ARP source
	logic arp_start;
	logic arp_data_valid;
	eth_tx_pkg::word_bytes_t arp_bytes_valid;
	eth_tx_pkg::tx_word_t arp_data;
	logic arp_commit;
	logic arp_drop;
	eth_tx_pkg::mac_addr_t arp_dst_mac;

	// IPv4 source
	logic ipv4_start;
	logic ipv4_data_valid;
	eth_tx_pkg::word_bytes_t ipv4_bytes_valid;
	eth_tx_pkg::tx_word_t ipv4_data;
	logic ipv4_commit;
	logic ipv4_drop;
	eth_tx_pkg::mac_addr_t ipv4_dst_mac;

	// MAC side
	logic tx_start;
	logic tx_data_valid;
	eth_tx_pkg::word_bytes_t tx_bytes_valid;
	eth_tx_pkg::tx_word_t tx_data;
	logic tx_commit;
	eth_tx_pkg::mac_addr_t tx_dst_mac;
	eth_tx_pkg::ethertype_t tx_ethertype;
	eth_tx_pkg::perf_count_t perf_arp_sent;
	eth_tx_pkg::perf_count_t perf_arp_dropped;
	eth_tx_pkg::perf_count_t perf_ipv4_sent;
	eth_tx_pkg::perf_count_t perf_ipv4_dropped;

	int cycle_count = 0;
	int mismatch_count = 0;
	int error_count = 0;
	int frame_count = 0;
	string cur_test = "reset";

	// Output monitor state
	logic mon_in_frame = 1'b0;
	logic mon_is_arp;
	logic [15:0] mon_type;
	eth_tx_pkg::mac_addr_t mon_exp_mac;
	int mon_words_left;
	int mon_bytes_left;
	int mon_lanes;
	int mon_lane;
	logic [7:0] mon_exp_byte;
	int last_start_cyc = 0;
	int last_commit_cyc = -10;
	// Ethertype of every closed frame, in output order
	logic [15:0] seen_types[$];

	eth_tx_mux_top dut0 (
		.clk(clk),
		.reset(reset),
		.arp_start(arp_start),
		.arp_data_valid(arp_data_valid),
		.arp_bytes_valid(arp_bytes_valid),
		.arp_data(arp_data),
		.arp_commit(arp_commit),
		.arp_drop(arp_drop),
		.arp_dst_mac(arp_dst_mac),
		.ipv4_start(ipv4_start),
		.ipv4_data_valid(ipv4_data_valid),
		.ipv4_bytes_valid(ipv4_bytes_valid),
		.ipv4_data(ipv4_data),
		.ipv4_commit(ipv4_commit),
		.ipv4_drop(ipv4_drop),
		.ipv4_dst_mac(ipv4_dst_mac),
		.tx_start(tx_start),
		.tx_data_valid(tx_data_valid),
		.tx_bytes_valid(tx_bytes_valid),
		.tx_data(tx_data),
		.tx_commit(tx_commit),
		.tx_dst_mac(tx_dst_mac),
		.tx_ethertype(tx_ethertype),
		.perf_arp_sent(perf_arp_sent),
		.perf_arp_dropped(perf_arp_dropped),
		.perf_ipv4_sent(perf_ipv4_sent),
		.perf_ipv4_dropped(perf_ipv4_dropped)
	);

	`include "eth_tx_mux_tasks.svh"

	//////////////////////////////
	// Clock, cycle count, timeout

	initial begin
		clk = 1'b0;
		forever begin
			#50 clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	initial begin
		wait (cycle_count >= CYCLE_LIMIT);
		$display("Timeout after %0d cycles, test %s never finished", CYCLE_LIMIT, cur_test);
		$display("Simulation failed");
		$finish;
	end

	//////////////////////////////
	// Output monitor

	// Sampled on the falling edge, half a cycle away from any DUT update
	always @(negedge clk) begin
		if (!reset) begin
			if (tx_start) begin
				if (mon_in_frame) begin
					report_error("tx_start arrived inside an open frame");
				end
				// One idle cycle must follow every commit
				if (cycle_count <= last_commit_cyc + 1) begin
					report_error("tx_start came before the arbiter was idle again");
				end
				mon_in_frame = 1'b0;
				// Header valid at the idle cycle decides, ARP first
				if (arp_cyc_q.size() != 0 && arp_cyc_q[0] <= cycle_count - 2) begin
					take_expected(1'b1);
				end else if (ipv4_cyc_q.size() != 0 && ipv4_cyc_q[0] <= cycle_count - 2) begin
					take_expected(1'b0);
				end else begin
					report_error("tx_start with no committed frame waiting");
				end
				if (mon_in_frame) begin
					last_start_cyc = cycle_count;
					if (tx_ethertype != mon_type) begin
						report_mismatch("ethertype", 64'(mon_type), 64'(tx_ethertype));
					end
					if (tx_dst_mac != mon_exp_mac) begin
						report_mismatch("dst_mac", 64'(mon_exp_mac), 64'(tx_dst_mac));
					end
				end
			end else if (mon_in_frame && mon_words_left > 0) begin
				if (!tx_data_valid || tx_commit) begin
					report_error("data word missing inside a frame");
					discard_expected_bytes();
				end else begin
					// Full words carry 4 bytes, the last one the remainder
					mon_lanes = (mon_bytes_left > 4) ? 4 : mon_bytes_left;
					if (tx_bytes_valid != 3'(mon_lanes)) begin
						report_mismatch("bytes_valid", 64'(mon_lanes), 64'(tx_bytes_valid));
					end
					for (mon_lane = 0; mon_lane < mon_lanes; mon_lane++) begin
						mon_exp_byte = pop_expected_byte(mon_is_arp);
						if (tx_data[8*mon_lane +: 8] != mon_exp_byte) begin
							report_mismatch("data byte", 64'(mon_exp_byte),
								64'(tx_data[8*mon_lane +: 8]));
						end
					end
					mon_bytes_left = mon_bytes_left - mon_lanes;
					mon_words_left = mon_words_left - 1;
				end
			end else if (mon_in_frame) begin
				if (!tx_commit || tx_data_valid) begin
					report_error("tx_commit missing right after the last data word");
				end
				// Header fields hold through the whole frame
				if (tx_dst_mac != mon_exp_mac) begin
					report_mismatch("held dst_mac", 64'(mon_exp_mac), 64'(tx_dst_mac));
				end
				if (tx_ethertype != mon_type) begin
					report_mismatch("held ethertype", 64'(mon_type), 64'(tx_ethertype));
				end
				mon_in_frame = 1'b0;
				last_commit_cyc = cycle_count;
				frame_count++;
				seen_types.push_back(tx_ethertype);
			end else if (tx_data_valid || tx_commit) begin
				report_error("data word or commit outside a frame");
			end
		end
	end

	//////////////////////////////
	// Test sequence

	initial begin
		void'($urandom(27912));
		reset = 1'b1;
		drive_source(1'b1, 1'b0, 1'b0, 3'd0, '0, 1'b0, 1'b0, '0);
		drive_source(1'b0, 1'b0, 1'b0, 3'd0, '0, 1'b0, 1'b0, '0);
		repeat (2) @(negedge clk);
		reset = 1'b0;
		check_reset_state();
		test_ipv4_single();
		test_drop_then_send();
		test_arp_priority();
		test_header_full();
		test_payload_full();
		$display("Run over: %0d mismatches, %0d other errors, %0d frames seen",
			mismatch_count, error_count, frame_count);
		if (mismatch_count == 0 && error_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
